//--- Bender.yml
package:
  name: dac_pattern

sources:
  - common/dac_pattern_pkg.sv
  - design/dac_prbs_gen.sv
  - design/dac_tone_gen.sv
  - prcfg_dac/prcfg_dac.sv
  - design/dac_pattern_regs.sv
  - design/dac_pattern_top.sv
  - target: test
    files:
      - tests/dac_pattern_assertions.sv
      - tests/dac_pattern_tb.sv

//--- common/dac_pattern_pkg.sv
// dac test-pattern shared definitions: sizes, mode codes, identifiers, generator constants
package dac_pattern_pkg;

  // ****************************************
  // sizes
  // ****************************************
  localparam int num_channels = 2;
  localparam int data_width   = 16;
  localparam int mode_width   = 4;

  // ****************************************
  // mode codes
  // ****************************************
  // any code above mode_pattern is treated as pass-through
  localparam logic [mode_width-1:0] mode_pass    = 4'd0;
  localparam logic [mode_width-1:0] mode_tone    = 4'd1;
  localparam logic [mode_width-1:0] mode_prbs    = 4'd2;
  localparam logic [mode_width-1:0] mode_pattern = 4'd3;

  // block identifier returned in the status word
  localparam logic [7:0] rp_id = 8'hA1;

  // pn generator start state
  localparam logic [data_width-1:0] prbs_seed = 16'hF19C;

  // alternating words of the pattern mode
  localparam logic [data_width-1:0] pattern_a = 16'h5555;
  localparam logic [data_width-1:0] pattern_b = 16'hAAAA;

  // eight-phase tone tables in 8-bit two's complement
  // cosine is the sine table advanced by two phases
  localparam logic signed [7:0] tone_sin [0:7] =
    '{8'h00, 8'h5A, 8'h7F, 8'h5A, 8'h00, 8'hA6, 8'h81, 8'hA6};
  localparam logic signed [7:0] tone_cos [0:7] =
    '{8'h7F, 8'h5A, 8'h00, 8'hA6, 8'h81, 8'hA6, 8'h00, 8'h5A};

  // i in the upper byte, q in the lower byte
  typedef struct packed {
    logic [7:0] i;
    logic [7:0] q;
  } dac_iq_t;

  // one dac sample seen either as a raw word or as an i/q pair
  typedef union packed {
    logic [data_width-1:0] raw;
    dac_iq_t               iq;
  } dac_word_t;

endpackage

//--- design/dac_pattern_regs.sv
// dac pattern register block: per-channel mode fields and the block status word
`timescale 1ns/10ps

module dac_pattern_regs (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 ctrl_wr,
  input  logic [31:0]                          ctrl_wdata,
  output logic [dac_pattern_pkg::num_channels-1:0][dac_pattern_pkg::mode_width-1:0] mode,
  output logic [31:0]                          status
);

  import dac_pattern_pkg::*;

  // ****************************************
  // mode fields
  // ****************************************
  // channel n owns bits 4n+3 down to 4n of the written word
  // all channels come out of reset in pass-through
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int n = 0; n < num_channels; n++) begin
        mode[n] <= mode_pass;
      end
    end else if (ctrl_wr) begin
      for (int n = 0; n < num_channels; n++) begin
        mode[n] <= ctrl_wdata[n*mode_width +: mode_width];
      end
    end
  end

  // ****************************************
  // status word
  // ****************************************
  // bits 7..0 block id
  // bits 15..8 channel count
  // upper half reads zero
  logic [31:0] status_value;

  assign status_value = {16'h0000, 8'(num_channels), rp_id};

  always_ff @(posedge clk) begin
    status <= status_value;
  end

endmodule

//--- design/dac_pattern_top.sv
// dac pattern top: register block feeding one pattern channel per dac channel
`timescale 1ns/10ps

module dac_pattern_top (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // control
  input  logic                                 ctrl_wr,
  input  logic [31:0]                          ctrl_wdata,
  output logic [31:0]                          status,

  // fifo side, one lane per channel
  input  logic [dac_pattern_pkg::num_channels-1:0][dac_pattern_pkg::data_width-1:0] src_data,
  output logic [dac_pattern_pkg::num_channels-1:0]                                  src_enable,
  output logic [dac_pattern_pkg::num_channels-1:0]                                  src_valid,

  // dac side, one lane per channel
  input  logic [dac_pattern_pkg::num_channels-1:0]                                  dst_enable,
  input  logic [dac_pattern_pkg::num_channels-1:0]                                  dst_valid,
  output logic [dac_pattern_pkg::num_channels-1:0][dac_pattern_pkg::data_width-1:0] dst_data
);

  import dac_pattern_pkg::*;

  // ****************************************
  // register block
  // ****************************************
  // modes settle one cycle after the write
  // and reach dst_data one cycle later
  logic [num_channels-1:0][mode_width-1:0] mode;

  dac_pattern_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl_wr    (ctrl_wr),
    .ctrl_wdata (ctrl_wdata),
    .mode       (mode),
    .status     (status)
  );

  // ****************************************
  // channels
  // ****************************************
  // each channel keeps its own generator state
  for (genvar ch = 0; ch < num_channels; ch++) begin : g_chan
    prcfg_dac u_chan (
      .clk        (clk),
      .rst_n      (rst_n),
      .mode       (mode[ch]),
      .src_data   (src_data[ch]),
      .src_enable (src_enable[ch]),
      .src_valid  (src_valid[ch]),
      .dst_enable (dst_enable[ch]),
      .dst_valid  (dst_valid[ch]),
      .dst_data   (dst_data[ch])
    );
  end

endmodule

//--- design/dac_prbs_gen.sv
// dac prbs generator: 16-bit pn sequence that advances one step per strobe
`timescale 1ns/10ps

module dac_prbs_gen (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                step,
  output logic [dac_pattern_pkg::data_width-1:0] prbs
);

  import dac_pattern_pkg::*;

  // ****************************************
  // next-state function
  // ****************************************
  // each bit takes its own value xor the bit below it
  // bit 0 closes the loop with the two top bits
  function automatic logic [data_width-1:0] pn_next(input logic [data_width-1:0] din);
    logic [data_width-1:0] dout;
    dout = '0;
    for (int k = 1; k < data_width; k++) begin
      dout[k] = din[k] ^ din[k-1];
    end
    dout[0] = din[14] ^ din[15] ^ din[0];
    return dout;
  endfunction

  // ****************************************
  // state register
  // ****************************************
  // seed on reset
  // hold while no sample is consumed
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prbs <= prbs_seed;
    end else if (step) begin
      prbs <= pn_next(prbs);
    end
  end

endmodule

//--- design/dac_tone_gen.sv
// dac tone generator: eight-phase sine/cosine lookup driving an i/q sample word
`timescale 1ns/10ps

module dac_tone_gen (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       step,
  output dac_pattern_pkg::dac_word_t tone
);

  import dac_pattern_pkg::*;

  // ****************************************
  // phase counter
  // ****************************************
  // three bits give the eight phases
  // natural wrap from 7 back to 0
  logic [2:0] phase;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= 3'd0;
    end else if (step) begin
      phase <= phase + 3'd1;
    end
  end

  // ****************************************
  // table lookup
  // ****************************************
  // output follows the current phase directly
  // the channel registers it, so a consumed sample shows the
  // phase from before the advance
  logic signed [7:0] cos_val;
  logic signed [7:0] sin_val;

  always_comb begin
    cos_val = tone_cos[phase];
    sin_val = tone_sin[phase];
  end

  // cosine goes on i, sine goes on q
  always_comb begin
    tone.iq.i = cos_val;
    tone.iq.q = sin_val;
  end

endmodule

//--- flist.f
common/dac_pattern_pkg.sv
design/dac_prbs_gen.sv
design/dac_tone_gen.sv
prcfg_dac/prcfg_dac.sv
design/dac_pattern_regs.sv
design/dac_pattern_top.sv
tests/dac_pattern_assertions.sv
tests/dac_pattern_tb.sv

//--- prcfg_dac/prcfg_dac.sv
// dac channel pattern source: pass-through, tone, prbs or alternating pattern onto the dac
`timescale 1ns/10ps

module prcfg_dac (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [dac_pattern_pkg::mode_width-1:0] mode,

  // fifo side
  input  logic [dac_pattern_pkg::data_width-1:0] src_data,
  output logic                                  src_enable,
  output logic                                  src_valid,

  // dac side
  input  logic                                  dst_enable,
  input  logic                                  dst_valid,
  output logic [dac_pattern_pkg::data_width-1:0] dst_data
);

  import dac_pattern_pkg::*;

  // ****************************************
  // consume strobe
  // ****************************************
  // one sample leaves per cycle with enable and valid both high
  logic consume;

  assign consume = dst_enable & dst_valid;

  // ****************************************
  // generators
  // ****************************************
  logic [data_width-1:0] prbs_word;
  dac_word_t             tone_word;
  logic                  toggle;
  logic [data_width-1:0] pattern_word;

  dac_prbs_gen u_prbs (
    .clk   (clk),
    .rst_n (rst_n),
    .step  (consume),
    .prbs  (prbs_word)
  );

  dac_tone_gen u_tone (
    .clk   (clk),
    .rst_n (rst_n),
    .step  (consume),
    .tone  (tone_word)
  );

  // alternating word toggle
  // starts on 0 so the first sample is pattern_b
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      toggle <= 1'b0;
    end else if (consume) begin
      toggle <= ~toggle;
    end
  end

  assign pattern_word = toggle ? pattern_a : pattern_b;

  // ****************************************
  // source select
  // ****************************************
  // unknown codes fall back to the fifo data
  logic                  pass_sel;
  logic [data_width-1:0] sel_data;

  always_comb begin
    pass_sel = 1'b1;
    sel_data = src_data;
    case (mode)
      mode_tone: begin
        pass_sel = 1'b0;
        sel_data = tone_word.raw;
      end
      mode_prbs: begin
        pass_sel = 1'b0;
        sel_data = prbs_word;
      end
      mode_pattern: begin
        pass_sel = 1'b0;
        sel_data = pattern_word;
      end
      default: begin
        pass_sel = 1'b1;
        sel_data = src_data;
      end
    endcase
  end

  // registered outputs, one cycle of latency on every path
  // valid back to the fifo only while its data is in use
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      src_enable <= 1'b0;
      src_valid  <= 1'b0;
      dst_data   <= '0;
    end else begin
      src_enable <= dst_enable;
      src_valid  <= pass_sel & dst_valid;
      dst_data   <= sel_data;
    end
  end

endmodule

//--- tests/dac_pattern_assertions.sv
// dac channel assertions: valid masking, enable latency and reset values
`timescale 1ns/10ps

module dac_pattern_assertions (
  input logic                                  clk,
  input logic                                  rst_n,
  input logic [dac_pattern_pkg::mode_width-1:0] mode,
  input logic                                  dst_enable,
  input logic                                  src_enable,
  input logic                                  src_valid,
  input logic [dac_pattern_pkg::data_width-1:0] dst_data
);

  import dac_pattern_pkg::*;

  // ****************************************
  // mode decode
  // ****************************************
  // generated data in use, fifo data dropped
  logic gen_mode;

  assign gen_mode = (mode == mode_tone) || (mode == mode_prbs) || (mode == mode_pattern);

  // ****************************************
  // properties
  // ****************************************
  // no valid back to the fifo while a generator feeds the dac
  property p_valid_masked;
    @(posedge clk) (rst_n && gen_mode) |=> !src_valid;
  endproperty

  // enable loops back after one register stage
  property p_enable_follows;
    @(posedge clk) rst_n |=> (src_enable == $past(dst_enable));
  endproperty

  // outputs cleared by a reset cycle
  property p_reset_clears;
    @(posedge clk) !rst_n |=> (!src_enable && !src_valid && dst_data == '0);
  endproperty

  a_valid_masked: assert property (p_valid_masked)
    else $error("src_valid high outside pass mode");

  a_enable_follows: assert property (p_enable_follows)
    else $error("src_enable does not follow dst_enable by one cycle");

  a_reset_clears: assert property (p_reset_clears)
    else $error("channel outputs not zero after reset");

endmodule

//--- tests/dac_pattern_tb.sv
// dac pattern testbench: random traffic and mode writes checked against a cycle model
`timescale 1ns/10ps

module dac_pattern_tb;

  import dac_pattern_pkg::*;

  // ****************************************
  // run length
  // ****************************************
  // four fixed-mode segments, then a mix with random mode writes
  localparam int seg_cycles     = 150;
  localparam int mix_cycles     = 600;
  localparam int planned_cycles = 4 * seg_cycles + mix_cycles;
  // margin on top of the planned length covers reset and setup writes
  localparam int timeout_cycles = planned_cycles + 800;

  // channel count in bits 15..8, block id in bits 7..0
  localparam logic [31:0] status_expected = 32'h0000_02A1;

  logic                                             clk;
  logic                                             rst_n;
  logic                                             ctrl_wr;
  logic [31:0]                                      ctrl_wdata;
  logic [31:0]                                      status;
  logic [num_channels-1:0][data_width-1:0]          src_data;
  logic [num_channels-1:0]                          src_enable;
  logic [num_channels-1:0]                          src_valid;
  logic [num_channels-1:0]                          dst_enable;
  logic [num_channels-1:0]                          dst_valid;
  logic [num_channels-1:0][data_width-1:0]          dst_data;

  // model state, one entry per channel
  logic [mode_width-1:0] m_mode   [num_channels];
  logic [2:0]            m_phase  [num_channels];
  logic [data_width-1:0] m_prbs   [num_channels];
  logic                  m_toggle [num_channels];

  logic [31:0] rng;
  int          error_count;
  int          cycle_count;

  dac_pattern_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl_wr    (ctrl_wr),
    .ctrl_wdata (ctrl_wdata),
    .status     (status),
    .src_data   (src_data),
    .src_enable (src_enable),
    .src_valid  (src_valid),
    .dst_enable (dst_enable),
    .dst_valid  (dst_valid),
    .dst_data   (dst_data)
  );

  // output checks inside every channel
  bind prcfg_dac dac_pattern_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .mode       (mode),
    .dst_enable (dst_enable),
    .src_enable (src_enable),
    .src_valid  (src_valid),
    .dst_data   (dst_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // hang guard
  initial cycle_count = 0;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: test did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAIL");
      $fatal(1, "run stopped by timeout");
    end
  end

  // ****************************************
  // helpers
  // ****************************************
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // pn step: bit k picks up bit k-1, bit 0 is fed by bits 15, 14 and 0
  function automatic logic [15:0] pn_step(input logic [15:0] s);
    return {s[15:1] ^ s[14:0], s[15] ^ s[14] ^ s[0]};
  endfunction

  // codes outside tone, prbs and pattern act as pass-through
  function automatic bit is_pass(input logic [mode_width-1:0] m);
    return !(m == mode_tone || m == mode_prbs || m == mode_pattern);
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  // random fifo data, enable and valid gaps, optional mode write
  task automatic drive_inputs(input bit allow_write);
    for (int ch = 0; ch < num_channels; ch++) begin
      rng = xorshift32(rng);
      src_data[ch]   = rng[15:0];
      dst_enable[ch] = (rng[17:16] != 2'b00);
      dst_valid[ch]  = (rng[19:18] != 2'b00);
    end
    rng = xorshift32(rng);
    ctrl_wr = allow_write && (rng[3:0] == 4'h0);
    rng = xorshift32(rng);
    ctrl_wdata = rng;
    // bias half the fields toward the four real codes
    for (int ch = 0; ch < num_channels; ch++) begin
      if (rng[24+ch]) begin
        ctrl_wdata[ch*mode_width+2 +: 2] = 2'b00;
      end
    end
  endtask

  // predict from the inputs now applied, clock once, compare
  task automatic step_and_check();
    logic [data_width-1:0] exp_data [num_channels];
    logic                  exp_en   [num_channels];
    logic                  exp_val  [num_channels];
    for (int ch = 0; ch < num_channels; ch++) begin
      exp_en[ch]  = dst_enable[ch];
      exp_val[ch] = is_pass(m_mode[ch]) & dst_valid[ch];
      case (m_mode[ch])
        mode_tone:    exp_data[ch] = {tone_cos[m_phase[ch]], tone_sin[m_phase[ch]]};
        mode_prbs:    exp_data[ch] = m_prbs[ch];
        mode_pattern: exp_data[ch] = m_toggle[ch] ? pattern_a : pattern_b;
        default:      exp_data[ch] = src_data[ch];
      endcase
      // generators move on consume only, whatever the mode
      if (dst_enable[ch] && dst_valid[ch]) begin
        m_phase[ch]  = m_phase[ch] + 3'd1;
        m_prbs[ch]   = pn_step(m_prbs[ch]);
        m_toggle[ch] = ~m_toggle[ch];
      end
    end
    if (ctrl_wr) begin
      for (int ch = 0; ch < num_channels; ch++) begin
        m_mode[ch] = ctrl_wdata[ch*mode_width +: mode_width];
      end
    end
    @(posedge clk);
    #1;
    for (int ch = 0; ch < num_channels; ch++) begin
      check_value($sformatf("dst_data[%0d]", ch), dst_data[ch], exp_data[ch]);
      check_value($sformatf("src_enable[%0d]", ch), src_enable[ch], exp_en[ch]);
      check_value($sformatf("src_valid[%0d]", ch), src_valid[ch], exp_val[ch]);
    end
    check_value("status", status, status_expected);
  endtask

  // ****************************************
  // main sequence
  // ****************************************
  initial begin
    rng         = 32'h70c7;
    error_count = 0;
    rst_n       = 1'b0;
    ctrl_wr     = 1'b0;
    ctrl_wdata  = '0;
    src_data    = '0;
    dst_enable  = '0;
    dst_valid   = '0;
    for (int ch = 0; ch < num_channels; ch++) begin
      m_mode[ch]   = mode_pass;
      m_phase[ch]  = 3'd0;
      m_prbs[ch]   = prbs_seed;
      m_toggle[ch] = 1'b0;
    end

    repeat (5) @(posedge clk);
    #1;
    // everything cleared by reset
    for (int ch = 0; ch < num_channels; ch++) begin
      check_value($sformatf("dst_data[%0d]", ch), dst_data[ch], '0);
      check_value($sformatf("src_enable[%0d]", ch), src_enable[ch], 1'b0);
      check_value($sformatf("src_valid[%0d]", ch), src_valid[ch], 1'b0);
    end
    check_value("status", status, status_expected);
    rst_n = 1'b1;

    // pass, tone, prbs, pattern on both channels in turn
    for (int seg = 0; seg < 4; seg++) begin
      drive_inputs(1'b0);
      ctrl_wr    = 1'b1;
      ctrl_wdata = {24'h0, 4'(seg), 4'(seg)};
      step_and_check();
      for (int i = 0; i < seg_cycles; i++) begin
        drive_inputs(1'b0);
        step_and_check();
      end
    end

    // random writes mix modes across the channels
    for (int i = 0; i < mix_cycles; i++) begin
      drive_inputs(1'b1);
      step_and_check();
    end

    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
